/* hw/noc_pkg.sv */
`default_nettype none

package noc_pkg;

    //////////////////////////////////////////////////////////////////////
    // router dimensions
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned num_ports   = 5;
    localparam int unsigned data_width  = 32;
    localparam int unsigned flit_width  = data_width + 2;
    localparam int unsigned queue_depth = 4;
    localparam int unsigned coord_width = 3;

    // derived widths
    localparam int unsigned port_idx_width = $clog2(num_ports);
    localparam int unsigned ptr_width      = $clog2(queue_depth);
    localparam int unsigned count_width    = $clog2(queue_depth + 1);

    //////////////////////////////////////////////////////////////////////
    // header layout
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned tail_bit  = data_width;
    localparam int unsigned head_bit  = data_width + 1;
    localparam int unsigned route_lsb = 0;
    localparam int unsigned route_msb = 4;
    localparam int unsigned dest_lsb  = 5;
    localparam int unsigned dest_msb  = 10;
    localparam int unsigned src_lsb   = 11;
    localparam int unsigned src_msb   = 16;

    typedef logic [flit_width-1:0] flit_t;

    typedef struct packed {
        logic [coord_width-1:0] x;
        logic [coord_width-1:0] y;
    } xy_t;

    // one bit per output direction, indexed by port_e
    typedef logic [num_ports-1:0] route_t;

    typedef enum logic [port_idx_width-1:0] {
        port_north = 3'd0,
        port_south = 3'd1,
        port_west  = 3'd2,
        port_east  = 3'd3,
        port_local = 3'd4
    } port_e;

    typedef enum logic [1:0] {
        st_reserve = 2'd0,
        st_head    = 2'd1,
        st_payload = 2'd2
    } state_e;

endpackage

`default_nettype wire

/* hw/router_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module router_fifo (
    input  logic           clk,
    input  logic           rst,
    input  logic           wr_i,
    input  noc_pkg::flit_t data_i,
    input  logic           rd_i,
    output noc_pkg::flit_t data_o,
    output logic           empty_o,
    output logic           full_o,
    output logic           almost_full_o
);
    import noc_pkg::*;

    flit_t                  mem [queue_depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    logic                   wr_en;
    logic                   rd_en;

    // writes are dropped when full, reads when empty
    assign wr_en = wr_i && !full_o;
    assign rd_en = rd_i && !empty_o;

    assign data_o        = mem[rd_ptr];
    assign empty_o       = (count == '0);
    assign full_o        = (count == count_width'(queue_depth));
    assign almost_full_o = (count >= count_width'(queue_depth - 1));

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_width'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_width'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // occupancy only moves when exactly one side is active
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/input_port.sv */
`timescale 1ns/100ps
`default_nettype none

module input_port (
    input  logic            clk,
    input  logic            rst,
    input  noc_pkg::flit_t  data_i,
    input  logic            void_i,
    input  logic            pop_i,
    output logic            stop_o,
    output noc_pkg::flit_t  head_flit_o,
    output logic            valid_o,
    output noc_pkg::route_t request_o,
    output logic            tail_o
);
    import noc_pkg::*;

    logic   empty;
    logic   head_valid;
    route_t saved_route;

    router_fifo queue_i (
        .clk           (clk),
        .rst           (rst),
        .wr_i          (~void_i),
        .data_i        (data_i),
        .rd_i          (pop_i),
        .data_o        (head_flit_o),
        .empty_o       (empty),
        .full_o        (),
        .almost_full_o (stop_o)
    );

    assign valid_o    = !empty;
    assign head_valid = valid_o && head_flit_o[head_bit];
    assign tail_o     = valid_o && head_flit_o[tail_bit];

    // a head at the queue front speaks for itself, the rest of the worm
    // reuses the route captured from it
    assign request_o = head_valid ? head_flit_o[route_msb:route_lsb] : saved_route;

    always_ff @(posedge clk) begin
        if (rst) begin
            saved_route <= '0;
        end else begin
            if (tail_o && pop_i) begin
                // worm finished, also covers single-flit worms
                saved_route <= '0;
            end else if (head_valid) begin
                saved_route <= head_flit_o[route_msb:route_lsb];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rr_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module rr_arbiter (
    input  logic            clk,
    input  logic            rst,
    input  noc_pkg::route_t request_i,
    input  logic            release_i,
    output noc_pkg::route_t grant_o,
    output logic            grant_valid_o
);
    import noc_pkg::*;

    logic [port_idx_width-1:0] ptr;
    logic [port_idx_width-1:0] last_idx;
    logic [port_idx_width-1:0] grant_idx;

    // cyclic search starting at the pointer
    always_comb begin
        int unsigned cand;
        grant_o       = '0;
        grant_valid_o = 1'b0;
        grant_idx     = ptr;
        for (int unsigned k = 0; k < num_ports; k++) begin
            cand = int'(ptr) + k;
            if (cand >= num_ports) begin
                cand = cand - num_ports;
            end
            if (!grant_valid_o && request_i[cand]) begin
                grant_valid_o = 1'b1;
                grant_o[cand] = 1'b1;
                grant_idx     = port_idx_width'(cand);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr      <= '0;
            last_idx <= '0;
        end else begin
            if (grant_valid_o) begin
                last_idx <= grant_idx;
            end
            // the input just served drops to lowest priority
            if (release_i) begin
                if (last_idx == port_idx_width'(num_ports - 1)) begin
                    ptr <= '0;
                end else begin
                    ptr <= last_idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/lookahead_route.sv */
`timescale 1ns/100ps
`default_nettype none

module lookahead_route #(
    parameter noc_pkg::port_e dir = noc_pkg::port_north
) (
    input  noc_pkg::xy_t    position_i,
    input  noc_pkg::xy_t    destination_i,
    output noc_pkg::route_t route_o
);
    import noc_pkg::*;

    xy_t next_pos;

    // position of the neighbour one hop away in direction dir
    always_comb begin
        next_pos = position_i;
        case (dir)
            port_north: next_pos.y = position_i.y - 1'b1;
            port_south: next_pos.y = position_i.y + 1'b1;
            port_west:  next_pos.x = position_i.x - 1'b1;
            port_east:  next_pos.x = position_i.x + 1'b1;
            default:    next_pos   = position_i;
        endcase
    end

    // XY dimension order: resolve x first, then y
    always_comb begin
        route_o = '0;
        if (destination_i.x > next_pos.x) begin
            route_o[port_east] = 1'b1;
        end else if (destination_i.x < next_pos.x) begin
            route_o[port_west] = 1'b1;
        end else if (destination_i.y < next_pos.y) begin
            route_o[port_north] = 1'b1;
        end else if (destination_i.y > next_pos.y) begin
            route_o[port_south] = 1'b1;
        end else begin
            route_o[port_local] = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/output_port.sv */
`timescale 1ns/100ps
`default_nettype none

module output_port #(
    parameter noc_pkg::port_e dir = noc_pkg::port_north
) (
    input  logic            clk,
    input  logic            rst,
    input  noc_pkg::xy_t    position_i,
    input  noc_pkg::route_t request_i [noc_pkg::num_ports],
    input  noc_pkg::flit_t  head_flit_i [noc_pkg::num_ports],
    input  logic            valid_i [noc_pkg::num_ports],
    input  logic            stop_i,
    output noc_pkg::route_t pop_o,
    output noc_pkg::flit_t  data_o,
    output logic            void_o
);
    import noc_pkg::*;

    state_e state;
    route_t arb_request;
    route_t grant;
    logic   grant_valid;
    route_t sel;
    flit_t  sel_flit;
    logic   sel_valid;
    logic   forwarding;
    logic   tail_fwd;
    route_t next_route;
    route_t head_route;
    flit_t  out_flit;

    //////////////////////////////////////////////////////////////////////
    // arbitration
    //////////////////////////////////////////////////////////////////////

    // requests only count while the output is free, and never from
    // the input on the same side
    always_comb begin
        arb_request = '0;
        if (state == st_reserve) begin
            for (int i = 0; i < num_ports; i++) begin
                if (i != int'(dir)) begin
                    arb_request[i] = request_i[i][dir];
                end
            end
        end
    end

    rr_arbiter arbiter_i (
        .clk           (clk),
        .rst           (rst),
        .request_i     (arb_request),
        .release_i     (tail_fwd),
        .grant_o       (grant),
        .grant_valid_o (grant_valid)
    );

    //////////////////////////////////////////////////////////////////////
    // crossbar and route insertion
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        sel_flit  = '0;
        sel_valid = 1'b0;
        for (int i = 0; i < num_ports; i++) begin
            if (sel[i]) begin
                sel_flit  = head_flit_i[i];
                sel_valid = valid_i[i];
            end
        end
    end

    assign forwarding = (state != st_reserve) && !stop_i && sel_valid;
    assign tail_fwd   = forwarding && sel_flit[tail_bit];
    assign pop_o      = forwarding ? sel : '0;

    lookahead_route #(
        .dir (dir)
    ) route_i (
        .position_i    (position_i),
        .destination_i (xy_t'(sel_flit[dest_msb:dest_lsb])),
        .route_o       (next_route)
    );

    // the flit leaving on the local port has arrived
    always_comb begin
        head_route = next_route;
        if (dir == port_local) begin
            head_route             = '0;
            head_route[port_local] = 1'b1;
        end
    end

    assign out_flit = sel_flit[head_bit] ? {sel_flit[flit_width-1:route_msb+1], head_route}
                                         : sel_flit;

    //////////////////////////////////////////////////////////////////////
    // worm FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_reserve;
            sel   <= '0;
        end else begin
            case (state)
                st_reserve: begin
                    if (grant_valid) begin
                        sel   <= grant;
                        state <= st_head;
                    end
                end
                st_head: begin
                    if (forwarding) begin
                        state <= tail_fwd ? st_reserve : st_payload;
                    end
                end
                st_payload: begin
                    if (tail_fwd) begin
                        state <= st_reserve;
                    end
                end
                default: state <= st_reserve;
            endcase
        end
    end

    // output register, frozen while downstream is stopped
    always_ff @(posedge clk) begin
        if (rst) begin
            void_o <= 1'b1;
        end else if (!stop_i) begin
            void_o <= !forwarding;
        end
    end

    always_ff @(posedge clk) begin
        if (forwarding) begin
            data_o <= out_flit;
        end
    end

endmodule

`default_nettype wire

/* hw/mesh_router.sv */
`timescale 1ns/100ps
`default_nettype none

module mesh_router (
    input  logic                          clk,
    input  logic                          rst,
    input  noc_pkg::xy_t                  position_i,
    input  noc_pkg::flit_t                data_n_i,
    input  noc_pkg::flit_t                data_s_i,
    input  noc_pkg::flit_t                data_w_i,
    input  noc_pkg::flit_t                data_e_i,
    input  noc_pkg::flit_t                data_l_i,
    input  logic [noc_pkg::num_ports-1:0] void_i,
    output logic [noc_pkg::num_ports-1:0] stop_o,
    output noc_pkg::flit_t                data_n_o,
    output noc_pkg::flit_t                data_s_o,
    output noc_pkg::flit_t                data_w_o,
    output noc_pkg::flit_t                data_e_o,
    output noc_pkg::flit_t                data_l_o,
    output logic [noc_pkg::num_ports-1:0] void_o,
    input  logic [noc_pkg::num_ports-1:0] stop_i
);
    import noc_pkg::*;

    flit_t  in_data   [num_ports];
    flit_t  out_data  [num_ports];
    route_t request   [num_ports];
    flit_t  head_flit [num_ports];
    logic   valid     [num_ports];
    route_t pop       [num_ports];
    logic   pop_in    [num_ports];

    assign in_data[port_north] = data_n_i;
    assign in_data[port_south] = data_s_i;
    assign in_data[port_west]  = data_w_i;
    assign in_data[port_east]  = data_e_i;
    assign in_data[port_local] = data_l_i;

    assign data_n_o = out_data[port_north];
    assign data_s_o = out_data[port_south];
    assign data_w_o = out_data[port_west];
    assign data_e_o = out_data[port_east];
    assign data_l_o = out_data[port_local];

    // an input is read when any output pops it
    always_comb begin
        for (int i = 0; i < num_ports; i++) begin
            pop_in[i] = 1'b0;
            for (int o = 0; o < num_ports; o++) begin
                pop_in[i] = pop_in[i] | pop[o][i];
            end
        end
    end

    for (genvar p = 0; p < num_ports; p++) begin : gen_port
        input_port in_i (
            .clk         (clk),
            .rst         (rst),
            .data_i      (in_data[p]),
            .void_i      (void_i[p]),
            .pop_i       (pop_in[p]),
            .stop_o      (stop_o[p]),
            .head_flit_o (head_flit[p]),
            .valid_o     (valid[p]),
            .request_o   (request[p]),
            .tail_o      ()
        );

        output_port #(
            .dir (port_e'(p))
        ) out_i (
            .clk         (clk),
            .rst         (rst),
            .position_i  (position_i),
            .request_i   (request),
            .head_flit_i (head_flit),
            .valid_i     (valid),
            .stop_i      (stop_i[p]),
            .pop_o       (pop[p]),
            .data_o      (out_data[p]),
            .void_o      (void_o[p])
        );
    end

endmodule

`default_nettype wire

/* bench/mesh_router_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module mesh_router_checker (
    input logic                                                   clk,
    input logic                                                   rst,
    input logic [noc_pkg::num_ports-1:0]                          stop_i,
    input logic [noc_pkg::num_ports-1:0]                          void_out_i,
    input logic [noc_pkg::num_ports-1:0]                          stop_out_i,
    input logic [noc_pkg::num_ports-1:0][noc_pkg::flit_width-1:0] flits_i
);
    import noc_pkg::*;

    // every input is open in the first cycle out of reset
    stop_clear_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> (stop_out_i == '0)
    ) else $error("stop_o not clear after reset");

    for (genvar o = 0; o < num_ports; o++) begin : gen_out
        // a stopped output keeps its void flag
        void_held: assert property (
            @(posedge clk) disable iff (rst)
            stop_i[o] |=> $stable(void_out_i[o])
        ) else $error("void_o[%0d] changed while stopped", o);

        // and keeps the flit it presents
        flit_held: assert property (
            @(posedge clk) disable iff (rst)
            (stop_i[o] && !void_out_i[o]) |=> $stable(flits_i[o])
        ) else $error("output %0d flit changed while stopped", o);

        head_route_onehot: assert property (
            @(posedge clk) disable iff (rst)
            (!void_out_i[o] && flits_i[o][head_bit]) |-> $onehot(flits_i[o][route_msb:route_lsb])
        ) else $error("head flit on output %0d has no one-hot route", o);
    end

endmodule

`default_nettype wire

/* bench/mesh_router_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mesh_router_tb;
    import noc_pkg::*;

    logic                 clk;
    logic                 rst = 1'b1;
    xy_t                  position = '{x: 3'd3, y: 3'd3};
    flit_t                data_in  [num_ports] = '{default: '0};
    flit_t                data_out [num_ports];
    logic [num_ports-1:0] void_i = '1;
    logic [num_ports-1:0] stop_o;
    logic [num_ports-1:0] void_o;
    logic [num_ports-1:0] stop_i = '0;

    string out_name [num_ports] = '{"data_n_o", "data_s_o", "data_w_o", "data_e_o", "data_l_o"};

    // flits waiting to be injected on each input
    flit_t send_q [num_ports][$];

    // expected worms indexed by the worm id in the payload bits
    flit_t exp_flit [128][8];
    int    exp_port [128];
    int    exp_len  [128];
    int    exp_pos  [128];
    int    cur_worm [num_ports] = '{default: -1};

    int worm_count  = 0;
    int delivered   = 0;
    int flits_total = 0;
    int cycle_count = 0;
    int stop_mode   = 0;
    int held_port   = 0;

    mesh_router mesh_router_i (
        .clk        (clk),
        .rst        (rst),
        .position_i (position),
        .data_n_i   (data_in[port_north]),
        .data_s_i   (data_in[port_south]),
        .data_w_i   (data_in[port_west]),
        .data_e_i   (data_in[port_east]),
        .data_l_i   (data_in[port_local]),
        .void_i     (void_i),
        .stop_o     (stop_o),
        .data_n_o   (data_out[port_north]),
        .data_s_o   (data_out[port_south]),
        .data_w_o   (data_out[port_west]),
        .data_e_o   (data_out[port_east]),
        .data_l_o   (data_out[port_local]),
        .void_o     (void_o),
        .stop_i     (stop_i)
    );

    bind mesh_router mesh_router_checker checker_i (
        .clk        (clk),
        .rst        (rst),
        .stop_i     (stop_i),
        .void_out_i (void_o),
        .stop_out_i (stop_o),
        .flits_i    ({data_l_o, data_e_o, data_w_o, data_s_o, data_n_o})
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // XY rule as seen by a router sitting at position at
    function automatic route_t xy_route(xy_t at, xy_t dest);
        route_t r;
        r = '0;
        if (dest.x > at.x) begin
            r[port_east] = 1'b1;
        end else if (dest.x < at.x) begin
            r[port_west] = 1'b1;
        end else if (dest.y < at.y) begin
            r[port_north] = 1'b1;
        end else if (dest.y > at.y) begin
            r[port_south] = 1'b1;
        end else begin
            r[port_local] = 1'b1;
        end
        return r;
    endfunction

    // route field a head flit carries when it leaves on output dir
    function automatic route_t expected_route(int dir, xy_t dest);
        xy_t next;
        next = position;
        case (dir)
            port_north: next.y = position.y - 1'b1;
            port_south: next.y = position.y + 1'b1;
            port_west:  next.x = position.x - 1'b1;
            port_east:  next.x = position.x + 1'b1;
            default:    return route_t'(1 << port_local);
        endcase
        return xy_route(next, dest);
    endfunction

    function automatic int port_of(route_t r);
        int idx;
        idx = -1;
        for (int i = 0; i < num_ports; i++) begin
            if (r[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic xy_t make_xy(int x, int y);
        xy_t r;
        r.x = x[2:0];
        r.y = y[2:0];
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checking helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // traffic generation
    //////////////////////////////////////////////////////////////////////

    // the source field tags the injecting input and the payload bits carry the worm id
    task automatic add_worm(int p, xy_t dest, int len);
        route_t here;
        xy_t    src;
        flit_t  f;
        int     idx;
        idx   = worm_count;
        here  = xy_route(position, dest);
        src.x = p[2:0];
        src.y = 3'd0;
        exp_port[idx] = port_of(here);
        exp_len[idx]  = len;
        exp_pos[idx]  = 0;
        for (int i = 0; i < len; i++) begin
            f[head_bit] = (i == 0);
            f[tail_bit] = (i == len - 1);
            f[data_width-1:src_msb+1] = idx;
            if (i == 0) begin
                f[src_msb:route_lsb] = {src, dest, here};
            end else begin
                f[src_msb:route_lsb] = $urandom;
            end
            send_q[p].push_back(f);
            if (i == 0) begin
                f[route_msb:route_lsb] = expected_route(exp_port[idx], dest);
            end
            exp_flit[idx][i] = f;
        end
        flits_total += len;
        worm_count++;
    endtask

    // destinations that would turn a worm back to its own side are redrawn
    task automatic random_worms(int count);
        xy_t    dest;
        route_t r;
        int     p;
        repeat (count) begin
            p = $urandom_range(num_ports - 1, 0);
            do begin
                dest.x = $urandom_range(7, 0);
                dest.y = $urandom_range(7, 0);
                r      = xy_route(position, dest);
            end while (r[p]);
            add_worm(p, dest, $urandom_range(6, 1));
        end
    endtask

    task automatic wait_drained();
        while (delivered < worm_count) begin
            @(posedge clk);
        end
    endtask

    // injection follows the stop_o seen at the edge
    always @(posedge clk) begin
        for (int p = 0; p < num_ports; p++) begin
            if (!rst && send_q[p].size() > 0 && !stop_o[p]) begin
                data_in[p] <= send_q[p].pop_front();
                void_i[p]  <= 1'b0;
            end else begin
                void_i[p] <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        for (int o = 0; o < num_ports; o++) begin
            case (stop_mode)
                1:       stop_i[o] <= ($urandom_range(2, 0) == 0);
                2:       stop_i[o] <= (o == held_port);
                default: stop_i[o] <= 1'b0;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output comparison
    //////////////////////////////////////////////////////////////////////

    // a flit is taken downstream on an edge where stop_i is low
    always @(posedge clk) begin
        flit_t f;
        int    idx;
        if (!rst) begin
            for (int o = 0; o < num_ports; o++) begin
                if (!void_o[o] && !stop_i[o]) begin
                    f = data_out[o];
                    if (f[head_bit]) begin
                        idx = f[data_width-1:src_msb+1];
                        if (cur_worm[o] >= 0 || idx >= worm_count) begin
                            $display("head flit on %s does not start a known worm", out_name[o]);
                            stop_with_failure();
                        end
                        check_value($sformatf("output port of worm %0d", idx), o, exp_port[idx]);
                        check_value($sformatf("flits seen of worm %0d", idx), exp_pos[idx], 0);
                        cur_worm[o] = idx;
                    end
                    if (cur_worm[o] < 0) begin
                        $display("flit on %s arrived outside any worm", out_name[o]);
                        stop_with_failure();
                    end
                    idx = cur_worm[o];
                    check_value(out_name[o], f, exp_flit[idx][exp_pos[idx]]);
                    exp_pos[idx]++;
                    if (f[tail_bit]) begin
                        cur_worm[o] = -1;
                        delivered++;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= 40 * flits_total + 1000) begin
            $display("run did not finish within %0d cycles, %0d of %0d worms delivered",
                     cycle_count, delivered, worm_count);
            stop_with_failure();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int saw_stop;
        void'($urandom(32'h46af));
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // single-flit worms in every direction
        add_worm(port_local, make_xy(3, 1), 1);
        add_worm(port_local, make_xy(3, 6), 1);
        add_worm(port_local, make_xy(0, 3), 1);
        add_worm(port_local, make_xy(7, 3), 1);
        add_worm(port_west, make_xy(3, 3), 1);
        wait_drained();

        // longer worms crossing west to east
        add_worm(port_west, make_xy(6, 3), 4);
        add_worm(port_west, make_xy(5, 1), 5);
        add_worm(port_west, make_xy(7, 6), 6);
        wait_drained();

        // north and local competing for east
        for (int i = 0; i < 4; i++) begin
            add_worm(port_north, make_xy(6, 2), 5);
            add_worm(port_local, make_xy(6, 2), 5);
        end
        wait_drained();

        stop_mode <= 1;
        random_worms(30);
        wait_drained();

        // east held stopped long enough to back up the west input
        held_port <= port_east;
        stop_mode <= 2;
        for (int i = 0; i < 6; i++) begin
            add_worm(port_west, make_xy(5, 3), 4);
        end
        saw_stop = 0;
        repeat (30) begin
            @(posedge clk);
            if (stop_o[port_west]) begin
                saw_stop = 1;
            end
        end
        check_value("stop_o[west] during hold", saw_stop, 1);
        stop_mode <= 0;
        wait_drained();

        random_worms(40);
        wait_drained();
        @(posedge clk);
        check_value("void_o", void_o, {num_ports{1'b1}});
        for (int w = 0; w < worm_count; w++) begin
            check_value($sformatf("flits left in worm %0d", w), exp_len[w] - exp_pos[w], 0);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hw/noc_pkg.sv
hw/router_fifo.sv
hw/input_port.sv
hw/rr_arbiter.sv
hw/lookahead_route.sv
hw/output_port.sv
hw/mesh_router.sv
bench/mesh_router_checker.sv
bench/mesh_router_tb.sv

/* Bender.yml */
package:
  name: mesh_router

sources:
  - files:
      - hw/noc_pkg.sv
      - hw/router_fifo.sv
      - hw/input_port.sv
      - hw/rr_arbiter.sv
      - hw/lookahead_route.sv
      - hw/output_port.sv
      - hw/mesh_router.sv
  - target: test
    files:
      - bench/mesh_router_checker.sv
      - bench/mesh_router_tb.sv
